//--- Bender.yml
package:
  name: icache

sources:
  - source/icachePkg.sv
  - source/wayPortIf.sv
  - source/cacheWay.sv
  - source/plruTree.sv
  - source/hitSelect.sv
  - source/fetchControl.sv
  - source/icacheTop.sv
  - target: test
    files:
      - verif/icacheTb.sv

//--- sim.f
source/icachePkg.sv
source/wayPortIf.sv
source/cacheWay.sv
source/plruTree.sv
source/hitSelect.sv
source/fetchControl.sv
source/icacheTop.sv
verif/icacheTb.sv

//--- source/cacheWay.sv
`timescale 1ns/1ps
`default_nettype none

module cacheWay (
    input  logic      clk,
    input  logic      rst,
    wayPortIf.way     port
);

    icachePkg::tagT  tagMem  [icachePkg::NumSets];
    icachePkg::lineT lineMem [icachePkg::NumSets];
    logic [icachePkg::NumSets-1:0] validBits;

    // tag array, synchronous read
    always_ff @(posedge clk) begin
        if (port.writeEn) begin
            tagMem[port.writeIndex] <= port.writeTag;
        end
        port.tagOut <= tagMem[port.readIndex];
    end

    // data array, same timing as the tags
    always_ff @(posedge clk) begin
        if (port.writeEn) begin
            lineMem[port.writeIndex] <= port.writeLine;
        end
        port.lineOut <= lineMem[port.readIndex];
    end

    // one valid bit per set, all cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (port.writeEn) begin
            validBits[port.writeIndex] <= 1'b1;
        end
    end

    // read sees the old bit when the same set is written on this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            port.validOut <= 1'b0;
        end else begin
            port.validOut <= validBits[port.readIndex];
        end
    end

endmodule

`default_nettype wire

//--- source/fetchControl.sv
`timescale 1ns/1ps
`default_nettype none

module fetchControl (
    input  logic            clk,
    input  logic            rst,
    input  logic            pcValid,
    input  icachePkg::addrT pc,
    input  logic            flush,
    input  logic            memRespValid,
    input  icachePkg::lineT memRespLine,
    input  logic            hit,
    input  icachePkg::wayT  hitWay,
    input  icachePkg::wayT  victim,
    input  icachePkg::instT word0,
    input  icachePkg::instT word1,
    wayPortIf.fill          fills [icachePkg::NumWays],
    output icachePkg::addrT lookupPc,
    output logic            useFill,
    output logic            plruUpdateEn,
    output icachePkg::wayT  plruWay,
    output logic            stall,
    output logic            inst0Valid,
    output icachePkg::instT inst0,
    output icachePkg::addrT inst0Pc,
    output logic            inst1Valid,
    output icachePkg::instT inst1,
    output icachePkg::addrT inst1Pc,
    output logic            memReqValid,
    output icachePkg::addrT memReqAddr
);

    icachePkg::fetchStateT state;
    icachePkg::fetchStateT nextState;
    icachePkg::addrT       pcReg;
    logic                  pendingLookup;
    logic                  requestSent;
    logic                  accept;
    logic                  lookupMiss;
    logic                  deliver;
    logic                  fillEn;

    assign accept     = pcValid && !stall;
    assign lookupMiss = (state == icachePkg::sRunning) && pendingLookup && !hit;

    always_ff @(posedge clk) begin
        if (accept) begin
            pcReg <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= icachePkg::sReset;
            pendingLookup <= 1'b0;
            requestSent   <= 1'b0;
        end else begin
            state         <= nextState;
            pendingLookup <= accept;
            if (memReqValid) begin
                requestSent <= 1'b1;
            end else if (memRespValid) begin
                requestSent <= 1'b0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::sReset: begin
                nextState = icachePkg::sRunning;
            end
            icachePkg::sRunning: begin
                // a flushed miss never issues its request
                if (lookupMiss && !flush) begin
                    nextState = icachePkg::sBlock;
                end
            end
            icachePkg::sBlock: begin
                if (memRespValid) begin
                    nextState = icachePkg::sRunning;
                end else if (flush && requestSent) begin
                    nextState = icachePkg::sRecover;
                end else if (flush) begin
                    nextState = icachePkg::sRunning;
                end
            end
            icachePkg::sRecover: begin
                if (memRespValid) begin
                    nextState = icachePkg::sRunning;
                end
            end
            default: begin
                nextState = icachePkg::sReset;
            end
        endcase
    end

    always_comb begin
        stall        = 1'b0;
        deliver      = 1'b0;
        fillEn       = 1'b0;
        useFill      = 1'b0;
        plruUpdateEn = 1'b0;
        plruWay      = hitWay;
        case (state)
            icachePkg::sReset: begin
                // held low while reset is asserted
                stall = !rst;
            end
            icachePkg::sRunning: begin
                if (pendingLookup && hit) begin
                    deliver      = 1'b1;
                    plruUpdateEn = 1'b1;
                end else if (pendingLookup) begin
                    stall = 1'b1;
                end
            end
            icachePkg::sBlock: begin
                // stall covers the refill edge so no read meets the write
                stall   = 1'b1;
                useFill = 1'b1;
                if (memRespValid && requestSent) begin
                    deliver      = 1'b1;
                    fillEn       = 1'b1;
                    plruUpdateEn = 1'b1;
                    plruWay      = victim;
                end
            end
            default: begin
                // recovery drops the response
                stall = 1'b1;
            end
        endcase
    end

    for (genvar i = 0; i < icachePkg::NumWays; i++) begin : gFill
        assign fills[i].writeEn    = fillEn && (victim == icachePkg::wayT'(i));
        assign fills[i].writeIndex = pcReg[icachePkg::OffsetBits +: icachePkg::IndexBits];
        assign fills[i].writeTag   =
            pcReg[icachePkg::OffsetBits + icachePkg::IndexBits +: icachePkg::TagBits];
        assign fills[i].writeLine  = memRespLine;
    end

    assign lookupPc    = pcReg;
    assign memReqValid = lookupMiss && !flush && !requestSent;
    assign memReqAddr  = {pcReg[31:icachePkg::OffsetBits], {icachePkg::OffsetBits{1'b0}}};

    assign inst0Valid = deliver && !flush && !pcReg[2];
    assign inst1Valid = deliver && !flush;
    assign inst0      = word0;
    assign inst1      = word1;
    assign inst0Pc    = {pcReg[31:3], 3'b000};
    assign inst1Pc    = {pcReg[31:3], 3'b100};

endmodule

`default_nettype wire

//--- source/hitSelect.sv
`timescale 1ns/1ps
`default_nettype none

module hitSelect (
    wayPortIf.lookup        ways [icachePkg::NumWays],
    input  icachePkg::addrT lookupPc,
    input  icachePkg::lineT fillLine,
    input  logic            useFill,
    output logic            hit,
    output icachePkg::wayT  hitWay,
    output icachePkg::instT word0,
    output icachePkg::instT word1
);

    icachePkg::tagT  lookupTag;
    logic [icachePkg::NumWays-1:0] match;
    icachePkg::lineT wayLine   [icachePkg::NumWays];
    icachePkg::lineT selLine;
    icachePkg::instT lineWords [icachePkg::WordsPerLine];
    logic [$clog2(icachePkg::WordsPerLine)-1:0] sel0;
    logic [$clog2(icachePkg::WordsPerLine)-1:0] sel1;

    assign lookupTag =
        lookupPc[icachePkg::OffsetBits + icachePkg::IndexBits +: icachePkg::TagBits];

    for (genvar i = 0; i < icachePkg::NumWays; i++) begin : gWay
        assign match[i]   = ways[i].validOut && (ways[i].tagOut == lookupTag);
        assign wayLine[i] = ways[i].lineOut;
    end

    assign hit = |match;

    // lowest matching way wins, scanned from the top so it is written last
    always_comb begin
        hitWay  = '0;
        selLine = wayLine[0];
        for (int i = icachePkg::NumWays - 1; i >= 0; i--) begin
            if (match[i]) begin
                hitWay  = icachePkg::wayT'(i);
                selLine = wayLine[i];
            end
        end
        if (useFill) begin
            selLine = fillLine;
        end
    end

    always_comb begin
        for (int k = 0; k < icachePkg::WordsPerLine; k++) begin
            lineWords[k] = selLine[32*k +: 32];
        end
    end

    // aligned pair, picked by pc bit 3
    assign sel0  = {lookupPc[3], 1'b0};
    assign sel1  = {lookupPc[3], 1'b1};
    assign word0 = lineWords[sel0];
    assign word1 = lineWords[sel1];

endmodule

`default_nettype wire

//--- source/icachePkg.sv
`default_nettype none

package icachePkg;

    localparam int NumWays      = 4;
    localparam int NumSets      = 64;
    localparam int OffsetBits   = 4;
    localparam int IndexBits    = 6;
    localparam int TagBits      = 22;
    localparam int LineBits     = 128;
    localparam int WordsPerLine = 4;

    // byte address, also used as the physical address
    typedef logic [31:0] addrT;

    typedef logic [31:0] instT;

    // address bits 31:10
    typedef logic [TagBits-1:0] tagT;

    // address bits 9:4
    typedef logic [IndexBits-1:0] indexT;

    // word k sits in bits 32k and up
    typedef logic [LineBits-1:0] lineT;

    typedef logic [$clog2(NumWays)-1:0] wayT;

    // bit 0 picks the pair, bit 1 the low pair member, bit 2 the high pair member
    typedef logic [NumWays-2:0] ageT;

    typedef enum logic [1:0] {
        sReset,
        sRunning,
        sBlock,
        sRecover
    } fetchStateT;

endpackage

`default_nettype wire

//--- source/icacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            pcValid,
    input  icachePkg::addrT pc,
    input  logic            flush,
    input  logic            memRespValid,
    input  icachePkg::lineT memRespLine,
    output logic            stall,
    output logic            inst0Valid,
    output icachePkg::instT inst0,
    output icachePkg::addrT inst0Pc,
    output logic            inst1Valid,
    output icachePkg::instT inst1,
    output icachePkg::addrT inst1Pc,
    output logic            memReqValid,
    output icachePkg::addrT memReqAddr
);

    wayPortIf wayBus [icachePkg::NumWays] ();

    logic             hit;
    icachePkg::wayT   hitWay;
    icachePkg::wayT   victim;
    icachePkg::instT  word0;
    icachePkg::instT  word1;
    icachePkg::addrT  lookupPc;
    icachePkg::indexT lookupIndex;
    logic             useFill;
    logic             plruUpdateEn;
    icachePkg::wayT   plruWay;

    assign lookupIndex = lookupPc[icachePkg::OffsetBits +: icachePkg::IndexBits];

    for (genvar i = 0; i < icachePkg::NumWays; i++) begin : gWay
        // RAMs index with the incoming pc
        assign wayBus[i].readIndex = pc[icachePkg::OffsetBits +: icachePkg::IndexBits];

        cacheWay way (
            .clk  (clk),
            .rst  (rst),
            .port (wayBus[i])
        );
    end

    plruTree plru (
        .clk         (clk),
        .rst         (rst),
        .updateEn    (plruUpdateEn),
        .updateIndex (lookupIndex),
        .updateWay   (plruWay),
        .victimIndex (lookupIndex),
        .victim      (victim)
    );

    hitSelect hitSel (
        .ways     (wayBus),
        .lookupPc (lookupPc),
        .fillLine (memRespLine),
        .useFill  (useFill),
        .hit      (hit),
        .hitWay   (hitWay),
        .word0    (word0),
        .word1    (word1)
    );

    fetchControl control (
        .clk          (clk),
        .rst          (rst),
        .pcValid      (pcValid),
        .pc           (pc),
        .flush        (flush),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .hit          (hit),
        .hitWay       (hitWay),
        .victim       (victim),
        .word0        (word0),
        .word1        (word1),
        .fills        (wayBus),
        .lookupPc     (lookupPc),
        .useFill      (useFill),
        .plruUpdateEn (plruUpdateEn),
        .plruWay      (plruWay),
        .stall        (stall),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst0Pc      (inst0Pc),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1),
        .inst1Pc      (inst1Pc),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr)
    );

endmodule

`default_nettype wire

//--- source/plruTree.sv
`timescale 1ns/1ps
`default_nettype none

module plruTree (
    input  logic             clk,
    input  logic             rst,
    input  logic             updateEn,
    input  icachePkg::indexT updateIndex,
    input  icachePkg::wayT   updateWay,
    input  icachePkg::indexT victimIndex,
    output icachePkg::wayT   victim
);

    icachePkg::ageT trees [icachePkg::NumSets];
    icachePkg::ageT victimTree;

    // each update points the tree away from the way just used
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < icachePkg::NumSets; i++) begin
                trees[i] <= '0;
            end
        end else if (updateEn) begin
            case (updateWay)
                2'd0: begin
                    trees[updateIndex][0] <= 1'b0;
                    trees[updateIndex][1] <= 1'b0;
                end
                2'd1: begin
                    trees[updateIndex][0] <= 1'b0;
                    trees[updateIndex][1] <= 1'b1;
                end
                2'd2: begin
                    trees[updateIndex][0] <= 1'b1;
                    trees[updateIndex][2] <= 1'b0;
                end
                default: begin
                    trees[updateIndex][0] <= 1'b1;
                    trees[updateIndex][2] <= 1'b1;
                end
            endcase
        end
    end

    assign victimTree = trees[victimIndex];

    always_comb begin
        if (victimTree[0] && victimTree[1]) begin
            victim = 2'd0;
        end else if (victimTree[0]) begin
            victim = 2'd1;
        end else if (victimTree[2]) begin
            victim = 2'd2;
        end else begin
            victim = 2'd3;
        end
    end

endmodule

`default_nettype wire

//--- source/wayPortIf.sv
`timescale 1ns/1ps
`default_nettype none

interface wayPortIf;

    icachePkg::indexT readIndex;
    logic             writeEn;
    icachePkg::indexT writeIndex;
    icachePkg::tagT   writeTag;
    icachePkg::lineT  writeLine;
    icachePkg::tagT   tagOut;
    icachePkg::lineT  lineOut;
    logic             validOut;

    modport way (
        input  readIndex, writeEn, writeIndex, writeTag, writeLine,
        output tagOut, lineOut, validOut
    );

    modport lookup (
        input tagOut, lineOut, validOut
    );

    modport fill (
        output writeEn, writeIndex, writeTag, writeLine
    );

endinterface

`default_nettype wire

//--- verif/icacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTb;

    localparam int NumTests = 19;
    localparam int MaxWait = 20;
    localparam int CyclesPerTest = 40;
    localparam time ClkPeriod = 10ns;
    localparam logic [31:0] WordMask = 32'h5a5a0000;

    logic            clk;
    logic            rst;
    logic            pcValid;
    icachePkg::addrT pc;
    logic            flush;
    logic            memRespValid;
    icachePkg::lineT memRespLine;
    logic            stall;
    logic            inst0Valid;
    icachePkg::instT inst0;
    icachePkg::addrT inst0Pc;
    logic            inst1Valid;
    icachePkg::instT inst1;
    icachePkg::addrT inst1Pc;
    logic            memReqValid;
    icachePkg::addrT memReqAddr;

    string           names [NumTests];
    icachePkg::addrT pcs [NumTests];
    bit              flushes [NumTests];
    bit              resets [NumTests];
    bit              misses [NumTests];

    // reference copy of valid bits, tags and PLRU trees
    bit          modelValid [64][4];
    logic [21:0] modelTag [64][4];
    logic [2:0]  modelTree [64];

    string curName;
    int    errCount;
    int    reqCount;

    icacheTop uut (
        .clk          (clk),
        .rst          (rst),
        .pcValid      (pcValid),
        .pc           (pc),
        .flush        (flush),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .stall        (stall),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst0Pc      (inst0Pc),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1),
        .inst1Pc      (inst1Pc),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %h, actual %h", curName, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic setEntry(input int idx, input string name, input icachePkg::addrT addr,
                            input bit doFlush, input bit doReset, input bit expMiss);
        names[idx]   = name;
        pcs[idx]     = addr;
        flushes[idx] = doFlush;
        resets[idx]  = doReset;
        misses[idx]  = expMiss;
    endtask

    task automatic buildTable();
        setEntry(0,  "cold",          32'h0000_1000, 0, 0, 1);
        setEntry(1,  "repeat",        32'h0000_1004, 0, 0, 0);
        setEntry(2,  "upperPair",     32'h0000_1008, 0, 0, 0);
        setEntry(3,  "upperOdd",      32'h0000_100c, 0, 0, 0);
        // five tags into set 5
        setEntry(4,  "setA",          32'h0000_0050, 0, 0, 1);
        setEntry(5,  "setB",          32'h0000_0454, 0, 0, 1);
        setEntry(6,  "setC",          32'h0000_0858, 0, 0, 1);
        setEntry(7,  "setD",          32'h0000_0c5c, 0, 0, 1);
        setEntry(8,  "setE",          32'h0000_1050, 0, 0, 1);
        setEntry(9,  "setAagain",     32'h0000_0050, 0, 0, 1);
        setEntry(10, "setDagain",     32'h0000_0c58, 0, 0, 0);
        setEntry(11, "setCagain",     32'h0000_085c, 0, 0, 0);
        setEntry(12, "setBagain",     32'h0000_0450, 0, 0, 1);
        setEntry(13, "flushMiss",     32'h0000_2020, 1, 0, 1);
        setEntry(14, "refetch",       32'h0000_2024, 0, 0, 1);
        setEntry(15, "refetchHit",    32'h0000_2020, 0, 0, 0);
        // flush on a hit cancels the delivery
        setEntry(16, "flushHit",      32'h0000_2028, 1, 0, 0);
        setEntry(17, "afterReset",    32'h0000_1000, 0, 1, 1);
        setEntry(18, "afterResetHit", 32'h0000_1004, 0, 0, 0);
    endtask

    task automatic clearModel();
        for (int s = 0; s < 64; s++) begin
            modelTree[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                modelValid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic lookupModel(input icachePkg::addrT addr, output bit isHit, output int way);
        int s;
        s = addr[9:4];
        isHit = 1'b0;
        way = 0;
        for (int w = 3; w >= 0; w--) begin
            if (modelValid[s][w] && modelTag[s][w] == addr[31:10]) begin
                isHit = 1'b1;
                way = w;
            end
        end
    endtask

    function automatic int pickVictim(input logic [2:0] tree);
        if (tree[0] && tree[1]) begin
            return 0;
        end else if (tree[0]) begin
            return 1;
        end else if (tree[2]) begin
            return 2;
        end
        return 3;
    endfunction

    task automatic touchTree(input int s, input int way);
        modelTree[s][0] = (way >= 2);
        if (way < 2) begin
            modelTree[s][1] = (way == 1);
        end else begin
            modelTree[s][2] = (way == 3);
        end
    endtask

    function automatic icachePkg::lineT makeLine(input icachePkg::addrT lineAddr);
        icachePkg::lineT line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = (lineAddr + 4*k) ^ WordMask;
        end
        return line;
    endfunction

    task automatic applyReset();
        @(posedge clk);
        rst     <= 1'b1;
        pcValid <= 1'b0;
        flush   <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            compareValue("stall in reset", 0, stall);
            compareValue("memReqValid in reset", 0, memReqValid);
            compareValue("valids in reset", 0, {inst0Valid, inst1Valid});
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        // one cycle in sReset with stall up
        compareValue("stall after reset", 1, stall);
        compareValue("valids after reset", 0, {inst0Valid, inst1Valid});
        clearModel();
    endtask

    // memory with a random latency per request
    initial begin : memoryModel
        icachePkg::addrT reqAddr;
        int              latency;
        void'($urandom(32'hfbecf046));
        forever begin
            @(negedge clk);
            if (memReqValid === 1'b1 && rst === 1'b0) begin
                reqCount++;
                reqAddr = memReqAddr;
                latency = 1 + ($urandom % 6);
                repeat (latency) @(posedge clk);
                memRespValid <= 1'b1;
                memRespLine  <= makeLine(reqAddr);
                @(posedge clk);
                memRespValid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #((NumTests + 2) * CyclesPerTest * ClkPeriod);
        $display("timeout: the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        bit              modelHit;
        int              modelWay;
        int              victimWay;
        int              setIdx;
        int              cycles;
        int              reqBefore;
        int              errBefore;
        int              passCount;
        icachePkg::addrT pairBase;
        clk          = 1'b0;
        rst          = 1'b1;
        pcValid      = 1'b0;
        pc           = '0;
        flush        = 1'b0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        errCount     = 0;
        reqCount     = 0;
        passCount    = 0;
        buildTable();
        clearModel();
        curName = "initialReset";
        applyReset();
        for (int i = 0; i < NumTests; i++) begin
            curName   = names[i];
            errBefore = errCount;
            if (resets[i]) begin
                applyReset();
            end
            lookupModel(pcs[i], modelHit, modelWay);
            setIdx   = pcs[i][9:4];
            pairBase = {pcs[i][31:3], 3'b000};
            @(posedge clk);
            pcValid <= 1'b1;
            pc      <= pcs[i];
            @(negedge clk);
            compareValue("stall before fetch", 0, stall);
            // acceptance edge
            @(posedge clk);
            pcValid   <= 1'b0;
            flush     <= flushes[i];
            reqBefore = reqCount;
            @(negedge clk);
            compareValue("miss vs table", misses[i], stall);
            compareValue("miss vs model", !modelHit, stall);
            if (flushes[i]) begin
                compareValue("inst0Valid", 0, inst0Valid);
                compareValue("inst1Valid", 0, inst1Valid);
                compareValue("memReqValid", 0, memReqValid);
                @(posedge clk);
                flush <= 1'b0;
                if (modelHit) begin
                    touchTree(setIdx, modelWay);
                end
            end else begin
                if (!modelHit) begin
                    compareValue("memReqValid", 1, memReqValid);
                    compareValue("memReqAddr", {pcs[i][31:4], 4'h0}, memReqAddr);
                end
                cycles = 0;
                while (inst1Valid !== 1'b1 && cycles < MaxWait) begin
                    @(negedge clk);
                    cycles++;
                    compareValue("stall while waiting", 1, stall);
                    compareValue("extra request", 0, memReqValid);
                end
                if (inst1Valid !== 1'b1) begin
                    $display("%s: no instruction pair came within %0d cycles", curName, MaxWait);
                    errCount++;
                end
                if (modelHit) begin
                    compareValue("hit latency", 0, cycles);
                end
                compareValue("inst0Valid", !pcs[i][2], inst0Valid);
                compareValue("inst0", pairBase ^ WordMask, inst0);
                compareValue("inst1", (pairBase | 32'h4) ^ WordMask, inst1);
                compareValue("inst0Pc", pairBase, inst0Pc);
                compareValue("inst1Pc", pairBase | 32'h4, inst1Pc);
                if (modelHit) begin
                    touchTree(setIdx, modelWay);
                end else begin
                    victimWay = pickVictim(modelTree[setIdx]);
                    modelValid[setIdx][victimWay] = 1'b1;
                    modelTag[setIdx][victimWay]   = pcs[i][31:10];
                    touchTree(setIdx, victimWay);
                end
            end
            @(negedge clk);
            compareValue("stall after fetch", 0, stall);
            compareValue("request count", (modelHit || flushes[i]) ? 0 : 1,
                         reqCount - reqBefore);
            if (errCount == errBefore) begin
                passCount++;
            end
            $display("test %0d %-14s %s", i, curName, (errCount == errBefore) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d ok, %0d with errors, %0d wrong values in all", NumTests,
                 passCount, NumTests - passCount, errCount);
        if (errCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
